//--- Bender.yml
package:
  name: toast_pipe_ctrl

sources:
  - files:
      - rtl/toast_def_pkg.sv
      - rtl/toast_decoder.sv
      - rtl/toast_hazards.sv
      - rtl/toast_branch_unit.sv
      - rtl/toast_stage_regs.sv
      - rtl/toast_pipe_ctrl.sv
  - target: test
    files:
      - verif/toast_clk_gen.sv
      - verif/tb_toast_pipe_ctrl.sv

//--- project.f
rtl/toast_def_pkg.sv
rtl/toast_decoder.sv
rtl/toast_hazards.sv
rtl/toast_branch_unit.sv
rtl/toast_stage_regs.sv
rtl/toast_pipe_ctrl.sv
verif/toast_clk_gen.sv
verif/tb_toast_pipe_ctrl.sv

//--- rtl/toast_branch_unit.sv
`timescale 1ns/100ps

module toast_branch_unit (
    input  toast_def_pkg::stage_ctrl_t     ex_ctrl_i, // instruction now in EX
    input  logic [toast_def_pkg::xlen-1:0] rs1_val_i,
    input  logic [toast_def_pkg::xlen-1:0] rs2_val_i,
    output logic                           branch_taken_o
);

    logic cond_met; // funct3 comparison result
    logic is_eq;
    logic lt_s;     // signed less-than
    logic lt_u;     // unsigned less-than

    assign is_eq = (rs1_val_i == rs2_val_i);
    assign lt_s  = ($signed(rs1_val_i) < $signed(rs2_val_i));
    assign lt_u  = (rs1_val_i < rs2_val_i);

    always_comb begin
        case (ex_ctrl_i.funct3)
            toast_def_pkg::funct3_beq: begin
                cond_met = is_eq;
            end
            toast_def_pkg::funct3_bne: begin
                cond_met = !is_eq;
            end
            toast_def_pkg::funct3_blt: begin
                cond_met = lt_s;
            end
            toast_def_pkg::funct3_bge: begin
                cond_met = !lt_s;
            end
            toast_def_pkg::funct3_bltu: begin
                cond_met = lt_u;
            end
            toast_def_pkg::funct3_bgeu: begin
                cond_met = !lt_u;
            end
            default: begin
                cond_met = 1'b0; // 010 and 011 are not branch codes
            end
        endcase
    end

    // bubbles and non-branches never redirect
    assign branch_taken_o = ex_ctrl_i.valid & ex_ctrl_i.branch & cond_met;

endmodule

//--- rtl/toast_decoder.sv
`timescale 1ns/100ps

module toast_decoder (
    input  toast_def_pkg::instr_u      instr_i, // word held in IF
    output toast_def_pkg::stage_ctrl_t ctrl_o   // control for the ID register
);

    always_comb begin
        ctrl_o = '0; // unknown opcode decodes to a bubble
        case (instr_i.r_fmt.opcode)
            toast_def_pkg::opcode_op: begin
                ctrl_o.valid  = 1'b1;
                ctrl_o.opcode = instr_i.r_fmt.opcode;
                ctrl_o.funct3 = instr_i.r_fmt.funct3;
                ctrl_o.rd     = instr_i.r_fmt.rd;
            end
            toast_def_pkg::opcode_op_imm: begin
                ctrl_o.valid  = 1'b1;
                ctrl_o.opcode = instr_i.i_fmt.opcode;
                ctrl_o.funct3 = instr_i.i_fmt.funct3;
                ctrl_o.rd     = instr_i.i_fmt.rd;
            end
            toast_def_pkg::opcode_load: begin
                ctrl_o.valid     = 1'b1;
                ctrl_o.opcode    = instr_i.i_fmt.opcode;
                ctrl_o.funct3    = instr_i.i_fmt.funct3; // access size
                ctrl_o.rd        = instr_i.i_fmt.rd;
                ctrl_o.mem_rd_en = 1'b1;
            end
            toast_def_pkg::opcode_store: begin
                ctrl_o.valid  = 1'b1;
                ctrl_o.opcode = instr_i.s_fmt.opcode;
                ctrl_o.funct3 = instr_i.s_fmt.funct3; // no rd, imm_lo sits there
            end
            toast_def_pkg::opcode_branch: begin
                ctrl_o.valid  = 1'b1;
                ctrl_o.opcode = instr_i.b_fmt.opcode;
                ctrl_o.funct3 = instr_i.b_fmt.funct3; // compare kind for EX
                ctrl_o.branch = 1'b1;
            end
            toast_def_pkg::opcode_jal: begin
                ctrl_o.valid  = 1'b1;
                ctrl_o.opcode = instr_i.j_fmt.opcode;
                ctrl_o.rd     = instr_i.j_fmt.rd; // link register
                ctrl_o.jump   = 1'b1;
            end
            toast_def_pkg::opcode_jalr: begin
                ctrl_o.valid  = 1'b1;
                ctrl_o.opcode = instr_i.i_fmt.opcode;
                ctrl_o.funct3 = instr_i.i_fmt.funct3;
                ctrl_o.rd     = instr_i.i_fmt.rd; // link register
                ctrl_o.jump   = 1'b1;
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

endmodule

//--- rtl/toast_def_pkg.sv
package toast_def_pkg;

    localparam int xlen       = 32; // data width
    localparam int ilen       = 32; // instruction word width
    localparam int reg_addr_w = 5;  // register file address width
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    // RV32I major opcodes used by this slice
    localparam logic [opcode_w-1:0] opcode_op     = 7'b0110011; // reg-reg alu
    localparam logic [opcode_w-1:0] opcode_op_imm = 7'b0010011; // reg-imm alu
    localparam logic [opcode_w-1:0] opcode_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] opcode_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] opcode_branch = 7'b1100011; // conditional branch
    localparam logic [opcode_w-1:0] opcode_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] opcode_jalr   = 7'b1100111;

    // funct3 codes of the branch class
    localparam logic [funct3_w-1:0] funct3_beq  = 3'b000;
    localparam logic [funct3_w-1:0] funct3_bne  = 3'b001;
    localparam logic [funct3_w-1:0] funct3_blt  = 3'b100; // signed
    localparam logic [funct3_w-1:0] funct3_bge  = 3'b101; // signed
    localparam logic [funct3_w-1:0] funct3_bltu = 3'b110; // unsigned
    localparam logic [funct3_w-1:0] funct3_bgeu = 3'b111; // unsigned

    typedef struct packed {
        logic [funct7_w-1:0]   funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [funct3_w-1:0]   funct3;
        logic [reg_addr_w-1:0] rd;
        logic [opcode_w-1:0]   opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;    // imm[11:0]
        logic [reg_addr_w-1:0] rs1;
        logic [funct3_w-1:0]   funct3;
        logic [reg_addr_w-1:0] rd;
        logic [opcode_w-1:0]   opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi; // imm[11:5]
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [funct3_w-1:0]   funct3;
        logic [4:0]            imm_lo; // imm[4:0]
        logic [opcode_w-1:0]   opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;    // sign bit of the offset
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [funct3_w-1:0]   funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [opcode_w-1:0]   opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;    // scrambled imm[20|10:1|11|19:12]
        logic [reg_addr_w-1:0] rd;
        logic [opcode_w-1:0]   opcode;
    } j_fmt_t;

    // one fetched word, viewed in every base format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // control carried from ID into EX, all zero is a bubble
    typedef struct packed {
        logic                  valid;     // known rv32i class
        logic [opcode_w-1:0]   opcode;
        logic [funct3_w-1:0]   funct3;
        logic [reg_addr_w-1:0] rd;        // zero for store and branch
        logic                  mem_rd_en; // load
        logic                  branch;    // conditional branch
        logic                  jump;      // jal or jalr
    } stage_ctrl_t;

endpackage

//--- rtl/toast_hazards.sv
`timescale 1ns/100ps

module toast_hazards (
    input  logic                                 clk_i,
    input  logic                                 resetn_i,
    input  toast_def_pkg::instr_u                if_instr_i,     // next consumer
    input  logic                                 id_mem_rd_en_i, // load sitting in ID
    input  logic [toast_def_pkg::reg_addr_w-1:0] id_rd_addr_i,   // load target
    input  logic                                 id_jump_en_i,   // jal or jalr in ID
    input  logic                                 ex_branch_en_i, // branch taken in EX
    output logic                                 stall_o,
    output logic                                 if_id_flush_o,
    output logic                                 ex_flush_o
);

    logic rs_hit;    // IF word reads the load target
    logic flush_now; // redirect seen this cycle
    logic flush_q;   // second cycle of the IF/ID flush

    // which source fields are real depends on the format of the IF word
    always_comb begin
        rs_hit = 1'b0;
        case (if_instr_i.r_fmt.opcode)
            toast_def_pkg::opcode_op: begin
                rs_hit = (if_instr_i.r_fmt.rs1 == id_rd_addr_i) ||
                         (if_instr_i.r_fmt.rs2 == id_rd_addr_i);
            end
            toast_def_pkg::opcode_store: begin
                rs_hit = (if_instr_i.s_fmt.rs1 == id_rd_addr_i) ||
                         (if_instr_i.s_fmt.rs2 == id_rd_addr_i);
            end
            toast_def_pkg::opcode_branch: begin
                rs_hit = (if_instr_i.b_fmt.rs1 == id_rd_addr_i) ||
                         (if_instr_i.b_fmt.rs2 == id_rd_addr_i);
            end
            toast_def_pkg::opcode_op_imm, toast_def_pkg::opcode_load: begin
                rs_hit = (if_instr_i.i_fmt.rs1 == id_rd_addr_i); // rs2 bits are imm here
            end
            default: begin
                rs_hit = 1'b0; // jumps and unknown words read nothing checked
            end
        endcase
    end

    assign stall_o = id_mem_rd_en_i & rs_hit; // load-use, one bubble

    assign flush_now = ex_branch_en_i | id_jump_en_i;

    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush_now; // stretch over the next cycle
        end
    end

    assign if_id_flush_o = flush_now | flush_q;
    assign ex_flush_o    = ex_branch_en_i; // only a branch has a wrong-path op in EX

endmodule

//--- rtl/toast_pipe_ctrl.sv
`timescale 1ns/100ps

module toast_pipe_ctrl (
    input  logic                           clk_i,
    input  logic                           resetn_i,
    input  logic [toast_def_pkg::ilen-1:0] instr_i,   // held by the source while stalled
    input  logic [toast_def_pkg::xlen-1:0] rs1_val_i, // operands of the EX instruction
    input  logic [toast_def_pkg::xlen-1:0] rs2_val_i,
    output logic                           stall_o,
    output logic                           if_id_flush_o,
    output logic                           ex_flush_o,
    output toast_def_pkg::stage_ctrl_t     ex_ctrl_o,
    output logic                           branch_taken_o
);

    toast_def_pkg::instr_u      if_instr;
    toast_def_pkg::stage_ctrl_t dec_ctrl; // decoder to ID register
    toast_def_pkg::stage_ctrl_t id_ctrl;
    toast_def_pkg::stage_ctrl_t ex_ctrl;
    logic                       stall;
    logic                       if_id_flush;
    logic                       ex_flush;
    logic                       branch_taken;

    toast_stage_regs u_stage_regs (
        .clk_i         (clk_i),
        .resetn_i      (resetn_i),
        .instr_i       (instr_i),
        .id_ctrl_i     (dec_ctrl),
        .stall_i       (stall),
        .if_id_flush_i (if_id_flush),
        .ex_flush_i    (ex_flush),
        .if_instr_o    (if_instr),
        .id_ctrl_o     (id_ctrl),
        .ex_ctrl_o     (ex_ctrl)
    );

    toast_decoder u_decoder (
        .instr_i (if_instr),
        .ctrl_o  (dec_ctrl)
    );

    toast_hazards u_hazards (
        .clk_i          (clk_i),
        .resetn_i       (resetn_i),
        .if_instr_i     (if_instr),
        .id_mem_rd_en_i (id_ctrl.mem_rd_en),
        .id_rd_addr_i   (id_ctrl.rd),
        .id_jump_en_i   (id_ctrl.jump),
        .ex_branch_en_i (branch_taken),
        .stall_o        (stall),
        .if_id_flush_o  (if_id_flush),
        .ex_flush_o     (ex_flush)
    );

    toast_branch_unit u_branch_unit (
        .ex_ctrl_i      (ex_ctrl),
        .rs1_val_i      (rs1_val_i),
        .rs2_val_i      (rs2_val_i),
        .branch_taken_o (branch_taken)
    );

    assign stall_o        = stall;
    assign if_id_flush_o  = if_id_flush;
    assign ex_flush_o     = ex_flush;
    assign ex_ctrl_o      = ex_ctrl;
    assign branch_taken_o = branch_taken;

endmodule

//--- rtl/toast_stage_regs.sv
`timescale 1ns/100ps

module toast_stage_regs (
    input  logic                       clk_i,
    input  logic                       resetn_i,
    input  toast_def_pkg::instr_u      instr_i,       // fetched this cycle
    input  toast_def_pkg::stage_ctrl_t id_ctrl_i,     // decoder output
    input  logic                       stall_i,
    input  logic                       if_id_flush_i,
    input  logic                       ex_flush_i,
    output toast_def_pkg::instr_u      if_instr_o,
    output toast_def_pkg::stage_ctrl_t id_ctrl_o,
    output toast_def_pkg::stage_ctrl_t ex_ctrl_o
);

    toast_def_pkg::instr_u      if_instr_q; // raw fetched word
    toast_def_pkg::stage_ctrl_t id_ctrl_q;  // decoded control
    toast_def_pkg::stage_ctrl_t ex_ctrl_q;  // control being executed

    // IF stage, flush wins over stall
    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            if_instr_q <= '0;
        end else if (if_id_flush_i) begin
            if_instr_q <= '0; // all zero word decodes as a bubble
        end else if (stall_i) begin
            if_instr_q <= if_instr_q; // keep the dependent word
        end else begin
            if_instr_q <= instr_i;
        end
    end

    // ID stage, a stall drops a bubble in behind the load
    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            id_ctrl_q <= '0;
        end else if (if_id_flush_i || stall_i) begin
            id_ctrl_q <= '0;
        end else begin
            id_ctrl_q <= id_ctrl_i;
        end
    end

    // EX stage, only a taken branch kills it
    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            ex_ctrl_q <= '0;
        end else if (ex_flush_i) begin
            ex_ctrl_q <= '0;
        end else begin
            ex_ctrl_q <= id_ctrl_q; // a jump in ID still moves on
        end
    end

    assign if_instr_o = if_instr_q;
    assign id_ctrl_o  = id_ctrl_q;
    assign ex_ctrl_o  = ex_ctrl_q;

endmodule

//--- verif/tb_toast_pipe_ctrl.sv
`timescale 1ns/100ps

module tb_toast_pipe_ctrl;

    // one cycle of stimulus plus what the DUT must show before the next edge
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic        stall;
        logic        if_id_flush;
        logic        ex_flush;
        logic        taken;
        logic        ex_valid;
        logic [6:0]  ex_opcode;
        logic [4:0]  ex_rd;
    } row_t;

    logic                       clk_i;
    logic                       resetn_i;
    logic [31:0]                instr_i;
    logic [31:0]                rs1_val_i;
    logic [31:0]                rs2_val_i;
    logic                       stall_o;
    logic                       if_id_flush_o;
    logic                       ex_flush_o;
    logic                       branch_taken_o;
    toast_def_pkg::stage_ctrl_t ex_ctrl_o;

    row_t rows[$];       // stimulus table, one entry per cycle
    int   cycle_count = 0;
    int   cycle_limit = 1000; // replaced once the table is built

    toast_clk_gen u_clk_gen (
        .clk_o    (clk_i),
        .resetn_o (resetn_i)
    );

    toast_pipe_ctrl dut (
        .clk_i          (clk_i),
        .resetn_i       (resetn_i),
        .instr_i        (instr_i),
        .rs1_val_i      (rs1_val_i),
        .rs2_val_i      (rs2_val_i),
        .stall_o        (stall_o),
        .if_id_flush_o  (if_id_flush_o),
        .ex_flush_o     (ex_flush_o),
        .ex_ctrl_o      (ex_ctrl_o),
        .branch_taken_o (branch_taken_o)
    );

    // RV32I encoders, straight from the base ISA layouts
    function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, toast_def_pkg::opcode_op}; // add
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opcode, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        logic [2:0] funct3;
        funct3 = (opcode == toast_def_pkg::opcode_load) ? 3'b010 : 3'b000; // lw or addi
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b010, 5'b00100, toast_def_pkg::opcode_store}; // sw +4
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] funct3, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        // offset 8, so bits 11:7 are nonzero and must not leak into rd
        return {1'b0, 6'b000000, rs2, rs1, funct3, 4'b0100, 1'b0, toast_def_pkg::opcode_branch};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd);
        return {20'h00100, rd, toast_def_pkg::opcode_jal};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [31:0] rs1_val,
                           input logic [31:0] rs2_val, input logic [3:0] flags,
                           input logic ex_valid, input logic [6:0] ex_opcode,
                           input logic [4:0] ex_rd);
        row_t r;
        r.instr   = instr;
        r.rs1_val = rs1_val;
        r.rs2_val = rs2_val;
        {r.stall, r.if_id_flush, r.ex_flush, r.taken} = flags; // flags in port order
        r.ex_valid  = ex_valid;
        r.ex_opcode = ex_opcode;
        r.ex_rd     = ex_rd;
        rows.push_back(r);
    endtask

    // taken branch after three quiet cycles, then four wrong-path words that never reach EX
    task automatic add_taken_branch(input logic [2:0] funct3, input logic [31:0] rs1_val,
                                    input logic [31:0] rs2_val);
        logic [31:0] wrong_path;
        wrong_path = enc_i(toast_def_pkg::opcode_op_imm, 5'd31, 5'd0, 12'h001);
        add_row(enc_b(funct3, 5'd1, 5'd2), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(wrong_path, 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(wrong_path, 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(wrong_path, rs1_val, rs2_val, 4'b0111, 1'b1, toast_def_pkg::opcode_branch, 5'd0);
        add_row(wrong_path, 32'd0, 32'd0, 4'b0100, 1'b0, 7'h00, 5'd0); // second flush cycle
    endtask

    task automatic build_table();
        logic [6:0]  op_alu;
        logic [6:0]  op_imm;
        logic [6:0]  op_ld;
        logic [6:0]  op_st;
        logic [6:0]  op_br;
        logic [31:0] ones;
        logic [31:0] wrong_path;
        logic [31:0] nop;
        op_alu     = toast_def_pkg::opcode_op;
        op_imm     = toast_def_pkg::opcode_op_imm;
        op_ld      = toast_def_pkg::opcode_load;
        op_st      = toast_def_pkg::opcode_store;
        op_br      = toast_def_pkg::opcode_branch;
        ones       = 32'hffff_ffff;
        wrong_path = enc_i(op_imm, 5'd31, 5'd0, 12'h001); // addi x31, x0, 1
        nop        = enc_i(op_imm, 5'd0, 5'd0, 12'h000);
        // independent words, EX shows each one three rows later
        add_row(enc_r(5'd1, 5'd2, 5'd3), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(enc_i(op_imm, 5'd4, 5'd5, 12'h007), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(enc_i(op_ld, 5'd6, 5'd7, 12'h000), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(enc_s(5'd9, 5'd8), 32'd0, 32'd0, 4'b0000, 1'b1, op_alu, 5'd1);
        add_row(enc_r(5'd10, 5'd6, 5'd11), 32'd0, 32'd0, 4'b0000, 1'b1, op_imm, 5'd4);
        add_row(enc_i(op_ld, 5'd12, 5'd13, 12'h000), 32'd0, 32'd0, 4'b0000, 1'b1, op_ld, 5'd6);
        // load x12 then add reading x12 in rs1
        add_row(enc_r(5'd14, 5'd12, 5'd15), 32'd0, 32'd0, 4'b0000, 1'b1, op_st, 5'd0);
        add_row(enc_i(op_ld, 5'd16, 5'd17, 12'h000), 32'd0, 32'd0, 4'b1000, 1'b1, op_alu, 5'd10);
        add_row(enc_i(op_ld, 5'd16, 5'd17, 12'h000), 32'd0, 32'd0, 4'b0000, 1'b1, op_ld, 5'd12);
        // store reading x16 in rs2
        add_row(enc_s(5'd19, 5'd16), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(enc_i(op_ld, 5'd20, 5'd21, 12'h000), 32'd0, 32'd0, 4'b1000, 1'b1, op_alu, 5'd14);
        add_row(enc_i(op_ld, 5'd20, 5'd21, 12'h000), 32'd0, 32'd0, 4'b0000, 1'b1, op_ld, 5'd16);
        // branch reading x20 in rs2
        add_row(enc_b(3'b000, 5'd22, 5'd20), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(enc_i(op_ld, 5'd24, 5'd25, 12'h000), 32'd0, 32'd0, 4'b1000, 1'b1, op_st, 5'd0);
        add_row(enc_i(op_ld, 5'd24, 5'd25, 12'h000), 32'd0, 32'd0, 4'b0000, 1'b1, op_ld, 5'd20);
        // imm bits 24:20 match the load target, no stall for I-type
        add_row(enc_i(op_ld, 5'd26, 5'd27, 12'h018), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(enc_i(op_imm, 5'd28, 5'd29, 12'h01a), 32'd1, 32'd2, 4'b0000, 1'b1, op_br, 5'd0);
        // jal, flush IF and ID for two cycles, jal itself goes on
        add_row(enc_jal(5'd1), 32'd0, 32'd0, 4'b0000, 1'b1, op_ld, 5'd24);
        add_row(wrong_path, 32'd0, 32'd0, 4'b0000, 1'b1, op_ld, 5'd26);
        add_row(wrong_path, 32'd0, 32'd0, 4'b0100, 1'b1, op_imm, 5'd28);
        add_row(wrong_path, 32'd0, 32'd0, 4'b0100, 1'b1, toast_def_pkg::opcode_jal, 5'd1);
        add_taken_branch(3'b000, 32'd5, 32'd5); // beq
        add_taken_branch(3'b001, 32'd5, 32'd6); // bne
        add_taken_branch(3'b100, ones, 32'd1);  // blt, -1 < 1
        add_taken_branch(3'b101, 32'd1, ones);  // bge
        add_taken_branch(3'b110, 32'd1, ones);  // bltu
        add_taken_branch(3'b111, ones, 32'd1);  // bgeu
        // bltu on the blt pair is not taken, the add behind it survives
        add_row(enc_b(3'b110, 5'd3, 5'd4), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(enc_r(5'd5, 5'd6, 5'd7), 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(nop, 32'd0, 32'd0, 4'b0000, 1'b0, 7'h00, 5'd0);
        add_row(nop, ones, 32'd1, 4'b0000, 1'b1, op_br, 5'd0);
        add_row(nop, 32'd0, 32'd0, 4'b0000, 1'b1, op_alu, 5'd5);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t: %s is 0x%0h, expected 0x%0h", $realtime, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_outputs(input string tag, input row_t exp);
        check_field({tag, " stall_o"}, stall_o, exp.stall);
        check_field({tag, " if_id_flush_o"}, if_id_flush_o, exp.if_id_flush);
        check_field({tag, " ex_flush_o"}, ex_flush_o, exp.ex_flush);
        check_field({tag, " branch_taken_o"}, branch_taken_o, exp.taken);
        check_field({tag, " ex_ctrl_o.valid"}, ex_ctrl_o.valid, exp.ex_valid);
        check_field({tag, " ex_ctrl_o.opcode"}, ex_ctrl_o.opcode, exp.ex_opcode);
        check_field({tag, " ex_ctrl_o.rd"}, ex_ctrl_o.rd, exp.ex_rd);
        if (!exp.ex_valid) begin
            check_field({tag, " ex_ctrl_o"}, ex_ctrl_o, 32'd0); // bubble is all zero
        end
    endtask

    // run limit, counts every rising edge from time zero
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        instr_i   = 32'd0;
        rs1_val_i = 32'd0;
        rs2_val_i = 32'd0;
        build_table();
        cycle_limit = 2 * rows.size() + 20;
        repeat (2) @(posedge clk_i); // registers cleared, reset still low
        #3.5;
        check_outputs("reset", '0);
        @(posedge resetn_i); // half a ns after the last reset edge
        foreach (rows[i]) begin
            instr_i   = rows[i].instr;
            rs1_val_i = rows[i].rs1_val;
            rs2_val_i = rows[i].rs2_val;
            #3; // just before the next edge
            check_outputs($sformatf("row %0d", i), rows[i]);
            @(posedge clk_i);
            #0.5;
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- verif/toast_clk_gen.sv
`timescale 1ns/100ps

module toast_clk_gen (
    output logic clk_o,
    output logic resetn_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o; // 4 ns period, first rising edge at 2 ns
        end
    end

    initial begin
        resetn_o = 1'b0;
        repeat (5) @(posedge clk_o); // five edges seen in reset
        #0.5;
        resetn_o = 1'b1; // released just after the edge, like any other input
    end

endmodule
